/* Bender.yml */
package:
  name: lane_fabric

sources:
  - files:
      - verilog/lane_pkg.sv
      - verilog/lane_distributor.sv
      - verilog/lane_stage.sv
      - verilog/cfg_regs.sv
      - verilog/lane_fabric_top.sv
  - target: test
    files:
      - tests/lane_fabric_assert.sv
      - tests/lane_fabric_tb.sv

/* lane_fabric.f */
verilog/lane_pkg.sv
verilog/lane_distributor.sv
verilog/lane_stage.sv
verilog/cfg_regs.sv
verilog/lane_fabric_top.sv
tests/lane_fabric_assert.sv
tests/lane_fabric_tb.sv

/* tests/lane_fabric_assert.sv */
// Concurrent checks on the output valid of the lane fabric
// Bound into lane_fabric_top

`timescale 1ns/1ps

module lane_fabric_assert (
	input logic clk,
	input logic rst,
	input logic vec_valid,
	input logic out_valid
);

	int fail_cnt = 0;  // Assertion failures so far

	// Output valid stays low while reset is held and on the first edge after it
	a_low_in_reset: assert property (@(posedge clk) rst |-> !out_valid)
		else begin
			$error("out_valid high while reset is asserted");
			fail_cnt++;
		end

	a_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid)
		else begin
			$error("out_valid high on the first edge after reset");
			fail_cnt++;
		end

	// Five stages sit between the lane vector and the output
	a_vec_to_out: assert property (@(posedge clk) disable iff (rst) vec_valid |-> ##5 out_valid)
		else begin
			$error("out_valid missing five cycles after a lane vector");
			fail_cnt++;
		end

	a_out_from_vec: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(vec_valid, 5))
		else begin
			$error("out_valid without a lane vector five cycles earlier");
			fail_cnt++;
		end

	a_valid_known: assert property (@(posedge clk) !$isunknown(out_valid))
		else begin
			$error("out_valid is unknown");
			fail_cnt++;
		end

endmodule

bind lane_fabric_top lane_fabric_assert lane_fabric_assert_i (
	.clk       (clk),
	.rst       (rst),
	.vec_valid (lane_vec.valid),
	.out_valid (out_valid)
);

/* tests/lane_fabric_tb.sv */
// Table-driven testbench for the three-lane fabric
// Reference model, output checker, timeout and summary

`timescale 1ns/1ps

module lane_fabric_tb;

	localparam int NROWS      = 7;
	localparam int STREAM_LEN = 30;
	localparam int TIMEOUT    = NROWS * 20 + STREAM_LEN + 100;

	// Stage kinds per lane as r for rotate, m for key mix and a for constant add
	localparam string LANE_ORDER [3] = '{"rrmmm", "mamra", "aarrr"};

	typedef struct {
		string           name;
		bit              cfg_on;
		logic [1:0]      cfg_a;
		lane_pkg::word_t cfg_d;
		lane_pkg::word_t smp [3];
		int              gap;    // Idle cycles between samples
		bit              send;   // Zero means 20 idle cycles instead of a group
		int              n_out;
	} row_t;

	row_t rows [NROWS] = '{
		'{"reset_state", 0, 2'd0, 32'h0, '{32'h0, 32'h0, 32'h0}, 0, 0, 0},
		'{"default_cfg", 0, 2'd0, 32'h0,
			'{32'h1234_5678, 32'h9ABC_DEF1, 32'h0F0F_0F0F}, 0, 1, 1},
		'{"add_const", 1, 2'd0, 32'h1000_0003,
			'{32'h1111_1111, 32'h2222_2222, 32'h3333_3333}, 0, 1, 1},
		'{"mix_key_odd", 1, 2'd1, 32'h5A5A_0FF0,
			'{32'h0000_0001, 32'h8000_0003, 32'hFFFF_FFFF}, 0, 1, 1},
		'{"mix_key_even", 0, 2'd0, 32'h0,
			'{32'h0000_0002, 32'h7FFF_FFFE, 32'hCAFE_BABE}, 0, 1, 1},
		'{"unknown_addr", 1, 2'd3, 32'hFFFF_FFFF,
			'{32'h0BAD_F00D, 32'h1357_9BDF, 32'h2468_ACE0}, 0, 1, 1},
		'{"gaps", 0, 2'd0, 32'h0, '{32'hDEAD_BEEF, 32'h0000_00FF, 32'h8765_4321}, 4, 1, 1}
	};

	logic                clk = 1'b0;
	logic                rst;
	logic                in_valid;
	lane_pkg::word_t     in_data;
	logic                cfg_we;
	lane_pkg::cfg_addr_e cfg_addr;
	lane_pkg::word_t     cfg_wdata;
	logic                out_valid;
	lane_pkg::word_t     out_data;

	int              cyc = 0;
	int              checks = 0;
	int              errors = 0;
	int              out_seen = 0;
	int              asrt_fails = 0;
	int              err_start;
	int              seen_start;
	string           cur_test = "reset";
	lane_pkg::word_t add_c = 32'h0000_0001;  // Model copy of the configuration
	lane_pkg::word_t key   = 32'hA5A5_A5A5;
	int              due_q [$];
	lane_pkg::word_t val_q [$];

	lane_fabric_top lane_fabric_top_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ========================================================================
	// Reference model and stimulus helpers
	// ========================================================================

	function automatic lane_pkg::word_t model_out(input lane_pkg::word_t smp [3],
			input lane_pkg::word_t a, input lane_pkg::word_t k);
		lane_pkg::word_t acc;
		lane_pkg::word_t w;
		acc = '0;
		for (int l = 0; l < 3; l++) begin
			w = smp[l];
			for (int s = 0; s < 5; s++) begin
				case (LANE_ORDER[l][s])
					"r": w = {w[23:0], w[31:24]};
					"m": if (w[0]) w = w ^ k;
					"a": w = w + a;
					default: w = w;
				endcase
			end
			acc = acc ^ w;
		end
		return acc;
	endfunction

	function automatic lane_pkg::word_t lcg_step(input lane_pkg::word_t s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic write_cfg(input logic [1:0] a, input lane_pkg::word_t d);
		@(negedge clk);
		cfg_we    = 1'b1;
		cfg_addr  = lane_pkg::cfg_addr_e'(a);
		cfg_wdata = d;
		if (a == 2'd0)
			add_c = d;
		else if (a == 2'd1)
			key = d;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	// The third sample of a group sets when the output is due
	task automatic drive_sample(input lane_pkg::word_t d, input bit last,
			input lane_pkg::word_t exp);
		@(negedge clk);
		in_valid = 1'b1;
		in_data  = d;
		if (last) begin
			due_q.push_back(cyc + lane_pkg::PIPE_LAT);
			val_q.push_back(exp);
		end
	endtask

	task automatic send_group(input lane_pkg::word_t smp [3], input int gap);
		for (int i = 0; i < 3; i++) begin
			if (i > 0)
				idle(gap);
			drive_sample(smp[i], i == 2, model_out(smp, add_c, key));
		end
		idle(1);
	endtask

	task automatic start_test(input string name);
		cur_test   = name;
		err_start  = errors;
		seen_start = out_seen;
	endtask

	task automatic close_test(input int n_out);
		while (due_q.size() != 0)
			@(negedge clk);
		idle(2);
		checks++;
		if (out_seen - seen_start != n_out) begin
			errors++;
			$display("Mismatch at %0t: %s expected %0d outputs but saw %0d", $time,
				cur_test, n_out, out_seen - seen_start);
		end
		if (lane_fabric_top_i.lane_fabric_assert_i.fail_cnt != asrt_fails) begin
			errors += lane_fabric_top_i.lane_fabric_assert_i.fail_cnt - asrt_fails;
			asrt_fails = lane_fabric_top_i.lane_fabric_assert_i.fail_cnt;
			$display("%s: an assertion on the output valid failed", cur_test);
		end
		$display("test %-14s %s", cur_test, (errors == err_start) ? "ok" : "failed");
	endtask

	// ========================================================================
	// Output checker
	// ========================================================================

	always @(negedge clk) begin
		if (!rst) begin
			if (out_valid)
				out_seen++;
			if (due_q.size() != 0 && due_q[0] == cyc) begin
				checks++;
				if (out_valid !== 1'b1) begin
					errors++;
					$display("Mismatch at %0t: %s out_valid low when an output was due",
						$time, cur_test);
				end else if (out_data !== val_q[0]) begin
					errors++;
					$display("Mismatch at %0t: %s out_data %h expected %h", $time, cur_test,
						out_data, val_q[0]);
				end
				void'(due_q.pop_front());
				void'(val_q.pop_front());
			end else if (out_valid !== 1'b0) begin
				errors++;
				$display("Mismatch at %0t: %s out_valid %b with no output due", $time,
					cur_test, out_valid);
			end
		end
	end

	initial begin
		wait (cyc >= TIMEOUT);
		$display("Timeout after %0d cycles, the outputs never drained", cyc);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		lane_pkg::word_t grp [3];
		lane_pkg::word_t lcg;
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_data   = '0;
		cfg_we    = 1'b0;
		cfg_addr  = lane_pkg::cfg_add_const;
		cfg_wdata = '0;
		lcg       = 32'd30836;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		for (int r = 0; r < NROWS; r++) begin
			start_test(rows[r].name);
			if (rows[r].cfg_on)
				write_cfg(rows[r].cfg_a, rows[r].cfg_d);
			if (rows[r].send)
				send_group(rows[r].smp, rows[r].gap);
			else
				idle(20);
			close_test(rows[r].n_out);
		end

		// Back-to-back groups with in_valid high every cycle
		start_test("stream");
		for (int i = 0; i < STREAM_LEN; i++) begin
			lcg        = lcg_step(lcg);
			grp[i % 3] = lcg;
			drive_sample(lcg, (i % 3) == 2, model_out(grp, add_c, key));
		end
		idle(1);
		close_test(STREAM_LEN / 3);

		$display("tests %0d, checks %0d, errors %0d", NROWS + 1, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verilog/cfg_regs.sv */
// Configuration registers for the lanes
// Add constant and mix key, written through a plain strobe

`timescale 1ns/1ps

module cfg_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cfg_we,
	input  lane_pkg::cfg_addr_e  cfg_addr,
	input  lane_pkg::word_t      cfg_wdata,
	output lane_pkg::cfg_t       cfg
);

	lane_pkg::word_t add_const_q;
	lane_pkg::word_t mix_key_q;

	// ========================================================================
	// Register writes
	// ========================================================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			add_const_q <= lane_pkg::CFG_ADD_RESET;
		end else if (cfg_we && (cfg_addr == lane_pkg::cfg_add_const)) begin
			add_const_q <= cfg_wdata;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mix_key_q <= lane_pkg::CFG_MIX_RESET;
		end else if (cfg_we && (cfg_addr == lane_pkg::cfg_mix_key)) begin
			mix_key_q <= cfg_wdata;
		end
	end

	// Writes to any other address fall through both decodes above

	// ========================================================================
	// Output to the stages
	// ========================================================================

	// New values reach the stages on the cycle after the write edge
	always_comb begin
		cfg.add_const = add_const_q;
		cfg.mix_key   = mix_key_q;
	end

endmodule

/* verilog/lane_distributor.sv */
// Input side of the fabric
// Groups three valid samples and issues them to the lanes in one cycle

`timescale 1ns/1ps

module lane_distributor (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  lane_pkg::word_t       in_data,
	output lane_pkg::lane_vec_t   lane_vec
);

	localparam logic [1:0] LAST_CNT = 2'(lane_pkg::LANES - 1);

	logic [1:0]                          grp_cnt;   // Samples already held, 0 to 2
	lane_pkg::word_t [lane_pkg::LANES-1:0] hold_q;
	lane_pkg::word_t [lane_pkg::LANES-1:0] hold_next;
	logic                                grp_done;

	// New sample enters at the top so the oldest ends up in word 0
	always_comb begin
		hold_next = {in_data, hold_q[lane_pkg::LANES-1:1]};
		grp_done  = in_valid && (grp_cnt == LAST_CNT);
	end

	// ========================================================================
	// Holding register and group counter
	// ========================================================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hold_q  <= '0;
			grp_cnt <= '0;
		end else if (in_valid) begin
			hold_q <= hold_next;
			if (grp_done)
				grp_cnt <= '0;
			else
				grp_cnt <= grp_cnt + 2'd1;
		end
	end

	// Lane vector, valid for one cycle per completed group
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_vec <= '0;
		end else begin
			lane_vec.valid <= grp_done;
			if (grp_done)
				lane_vec.word <= hold_next;  // Words stay put between groups
		end
	end

endmodule

/* verilog/lane_fabric_top.sv */
// Top level of the three-lane fabric
// Distributor, configuration block, five-stage lanes and the XOR merge

`timescale 1ns/1ps

module lane_fabric_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  lane_pkg::word_t      in_data,
	input  logic                 cfg_we,
	input  lane_pkg::cfg_addr_e  cfg_addr,
	input  lane_pkg::word_t      cfg_wdata,
	output logic                 out_valid,
	output lane_pkg::word_t      out_data
);

	lane_pkg::lane_vec_t   lane_vec;
	lane_pkg::cfg_t        cfg;

	// Bus between stages, index 0 is the lane input and STAGES the lane result
	lane_pkg::stage_bus_t  chain [lane_pkg::LANES][lane_pkg::STAGES+1];

	// ========================================================================
	// Input side and configuration
	// ========================================================================

	lane_distributor lane_distributor_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_data  (in_data),
		.lane_vec (lane_vec)
	);

	cfg_regs cfg_regs_i (
		.clk       (clk),
		.rst       (rst),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	// ========================================================================
	// Lanes
	// ========================================================================

	for (genvar l = 0; l < lane_pkg::LANES; l++) begin : g_lane
		assign chain[l][0].valid = lane_vec.valid;
		assign chain[l][0].data  = lane_vec.word[l];  // Lane k takes word k

		for (genvar s = 0; s < lane_pkg::STAGES; s++) begin : g_stage
			lane_stage lane_stage_i (
				.clk       (clk),
				.rst       (rst),
				.op        (lane_pkg::LANE_OPS[l][s]),
				.cfg       (cfg),
				.stage_in  (chain[l][s]),
				.stage_out (chain[l][s+1])
			);
		end
	end

	// ========================================================================
	// Output merge
	// ========================================================================

	// All lanes run in lockstep so lane 0 carries the output valid
	assign out_valid = chain[0][lane_pkg::STAGES].valid;

	always_comb begin
		out_data = '0;
		for (int l = 0; l < lane_pkg::LANES; l++)
			out_data = out_data ^ chain[l][lane_pkg::STAGES].data;
	end

endmodule

/* verilog/lane_pkg.sv */
// Shared sizes, enums and bus structs for the three-lane fabric
// Also holds the per-lane stage order and the configuration reset values

package lane_pkg;

	// ========================================================================
	// Sizes and timing
	// ========================================================================

	localparam int WORD_W   = 32;
	localparam int LANES    = 3;
	localparam int STAGES   = 5;
	localparam int PIPE_LAT = 6;  // Distributor register plus one cycle per stage
	localparam int ROT_AMT  = 8;  // Left rotate amount of a rotate stage

	typedef logic [WORD_W-1:0] word_t;

	// ========================================================================
	// Enums
	// ========================================================================

	typedef enum logic [1:0] {
		op_rotate = 2'd0,
		op_mix    = 2'd1,
		op_add    = 2'd2
	} stage_op_e;

	// Two addresses are decoded, the rest of the space is ignored
	typedef enum logic [1:0] {
		cfg_add_const = 2'd0,
		cfg_mix_key   = 2'd1
	} cfg_addr_e;

	// ========================================================================
	// Bus structs
	// ========================================================================

	typedef struct packed {
		logic                   valid;
		word_t [LANES-1:0]      word;  // Word 0 is the oldest sample of the group
	} lane_vec_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} stage_bus_t;

	typedef struct packed {
		word_t add_const;
		word_t mix_key;
	} cfg_t;

	// Stage kinds per lane, stage 0 sits next to the distributor
	localparam stage_op_e LANE_OPS [LANES][STAGES] = '{
		'{op_rotate, op_rotate, op_mix,    op_mix,    op_mix},
		'{op_mix,    op_add,    op_mix,    op_rotate, op_add},
		'{op_add,    op_add,    op_rotate, op_rotate, op_rotate}
	};

	localparam word_t CFG_ADD_RESET = 32'h0000_0001;
	localparam word_t CFG_MIX_RESET = 32'hA5A5_A5A5;

endpackage

/* verilog/lane_stage.sv */
// One registered stage of a lane
// Rotate, key mix or constant add, chosen by the op input

`timescale 1ns/1ps

module lane_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  lane_pkg::stage_op_e   op,
	input  lane_pkg::cfg_t        cfg,
	input  lane_pkg::stage_bus_t  stage_in,
	output lane_pkg::stage_bus_t  stage_out
);

	localparam int W = lane_pkg::WORD_W;
	localparam int R = lane_pkg::ROT_AMT;

	lane_pkg::word_t rot_word;
	lane_pkg::word_t mix_word;
	lane_pkg::word_t add_word;
	lane_pkg::word_t next_word;

	// ========================================================================
	// Transforms
	// ========================================================================

	// Left rotate, the top byte wraps around to the bottom
	assign rot_word = {stage_in.data[W-R-1:0], stage_in.data[W-1:W-R]};

	// Key mix only applies to odd words
	always_comb begin
		if (stage_in.data[0])
			mix_word = stage_in.data ^ cfg.mix_key;
		else
			mix_word = stage_in.data;
	end

	assign add_word = stage_in.data + cfg.add_const;  // Wraps modulo 2^32

	always_comb begin
		case (op)
			lane_pkg::op_rotate: next_word = rot_word;
			lane_pkg::op_mix:    next_word = mix_word;
			lane_pkg::op_add:    next_word = add_word;
			default:             next_word = stage_in.data;
		endcase
	end

	// ========================================================================
	// Stage register
	// ========================================================================

	// Data is registered every cycle, the valid bit marks the useful ones
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_out.valid <= 1'b0;
			stage_out.data  <= '0;
		end else begin
			stage_out.valid <= stage_in.valid;
			stage_out.data  <= next_word;
		end
	end

endmodule
